// ==== hdl/hl_pkg.sv ====
/* downstream protocol definitions */
`default_nettype none

package hl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // packet framing

  // every protocol packet opens with these two bytes
  localparam logic [7:0] ETH_SYNC0 = 8'hEF;
  localparam logic [7:0] ETH_SYNC1 = 8'hFE;

  // packet type byte
  localparam logic [7:0] PKT_DATA       = 8'h01;
  localparam logic [7:0] PKT_DISCOVERY  = 8'h02;
  localparam logic [7:0] PKT_START_STOP = 8'h04;

  localparam logic [15:0] DATA_PORT = 16'd1024;

  // three of these open each usb frame
  localparam logic [7:0] FRAME_SYNC = 8'h7F;

  localparam int ETH_HDR_LEN     = 8;
  localparam int USB_FRAME_LEN   = 512;
  localparam int SLOTS_PER_FRAME = 63;

  ////////////////////////////////////////////////////////////////////////////
  // command bus

  localparam int CMD_ADDR_W = 6;

  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [31:0]           cmd_data_t;

  localparam cmd_addr_t REG_CONFIG   = cmd_addr_t'(0);
  localparam cmd_addr_t REG_TX_FREQ  = cmd_addr_t'(1);
  localparam cmd_addr_t REG_RX1_FREQ = cmd_addr_t'(2);

  ////////////////////////////////////////////////////////////////////////////
  // sample words, first value in the upper half

  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } lr_sample_t;

  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } iq_sample_t;

endpackage

`default_nettype wire

// ==== hdl/ds_frame_parser.sv ====
/* downstream packet and usb frame parser */
`timescale 1ns/1ps
`default_nettype none

module ds_frame_parser import hl_pkg::*; (
  input  wire logic        clk_ctrl,
  input  wire logic        rst_n_i,
  input  wire logic        eth_valid_i,
  input  wire logic [7:0]  eth_data_i,
  input  wire logic [15:0] eth_port_i,
  input  wire logic        eth_broadcast_i,
  output logic             cmd_stb_o,
  output cmd_addr_t        cmd_addr_o,
  output cmd_data_t        cmd_data_o,
  output logic             cmd_ptt_o,
  output logic             cmd_resp_o,
  output logic [7:0]       smp_byte_o,
  output logic             smp_byte_vld_o,
  output logic             slot_start_o,
  output logic             run_o,
  output logic             wide_spectrum_o,
  output logic             discovery_o
);

  localparam int HDR_W   = $clog2(ETH_HDR_LEN);
  localparam int FRM_W   = $clog2(USB_FRAME_LEN);
  // sync bytes plus C0..C4, slots follow
  localparam int FRM_HDR = USB_FRAME_LEN - 8 * SLOTS_PER_FRAME;

  typedef enum logic [1:0] {ST_HDR, ST_FRAME, ST_IGNORE} state_t;

  state_t           state;
  logic [HDR_W-1:0] hdr_cnt;
  logic [FRM_W-1:0] frm_cnt;
  logic             frame_idx;
  logic             sync_ok;
  logic [7:0]       pkt_type;
  logic [7:0]       c0;
  logic [23:0]      data_sr;
  logic [2:0]       slot_byte;

  assign slot_byte = 3'(frm_cnt - FRM_W'(FRM_HDR));

  ////////////////////////////////////////////////////////////////////////////
  // packet walker

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      state           <= ST_HDR;
      hdr_cnt         <= '0;
      frm_cnt         <= '0;
      frame_idx       <= 1'b0;
      sync_ok         <= 1'b1;
      pkt_type        <= '0;
      run_o           <= 1'b0;
      wide_spectrum_o <= 1'b0;
      discovery_o     <= 1'b0;
      cmd_stb_o       <= 1'b0;
      smp_byte_vld_o  <= 1'b0;
      slot_start_o    <= 1'b0;
    end else begin
      discovery_o    <= 1'b0;
      cmd_stb_o      <= 1'b0;
      smp_byte_vld_o <= 1'b0;
      slot_start_o   <= 1'b0;
      if (!eth_valid_i) begin
        // gap between packets
        state     <= ST_HDR;
        hdr_cnt   <= '0;
        frm_cnt   <= '0;
        frame_idx <= 1'b0;
        sync_ok   <= 1'b1;
      end else begin
        case (state)
          ST_HDR: begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == HDR_W'(0)) begin
              if (eth_data_i != ETH_SYNC0 || eth_port_i != DATA_PORT) state <= ST_IGNORE;
            end else if (hdr_cnt == HDR_W'(1)) begin
              if (eth_data_i != ETH_SYNC1) state <= ST_IGNORE;
            end else if (hdr_cnt == HDR_W'(2)) begin
              pkt_type <= eth_data_i;
              if (eth_data_i == PKT_DISCOVERY) begin
                discovery_o <= eth_broadcast_i;
                state       <= ST_IGNORE;
              end else if (eth_data_i != PKT_DATA && eth_data_i != PKT_START_STOP) begin
                state <= ST_IGNORE;
              end
            end else if (hdr_cnt == HDR_W'(3) && pkt_type == PKT_START_STOP) begin
              run_o           <= eth_data_i[0];
              wide_spectrum_o <= eth_data_i[1];
              state           <= ST_IGNORE;
            end else if (hdr_cnt == HDR_W'(ETH_HDR_LEN - 1)) begin
              state <= ST_FRAME;
            end
          end
          ST_FRAME: begin
            if (frm_cnt < FRM_W'(3) && eth_data_i != FRAME_SYNC) sync_ok <= 1'b0;
            // C4 completes the command
            if (frm_cnt == FRM_W'(7)) cmd_stb_o <= sync_ok;
            if (frm_cnt >= FRM_W'(FRM_HDR)) begin
              smp_byte_vld_o <= sync_ok;
              slot_start_o   <= sync_ok && slot_byte == 3'd0;
            end
            if (frm_cnt == FRM_W'(USB_FRAME_LEN - 1)) begin
              frm_cnt   <= '0;
              sync_ok   <= 1'b1;
              frame_idx <= 1'b1;
              if (frame_idx) state <= ST_IGNORE;
            end else begin
              frm_cnt <= frm_cnt + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // command and sample payload

  always_ff @(posedge clk_ctrl) begin
    smp_byte_o <= eth_data_i;
    if (state == ST_FRAME && eth_valid_i) begin
      if (frm_cnt == FRM_W'(3)) c0 <= eth_data_i;
      // C1..C3, msb first
      if (frm_cnt > FRM_W'(3) && frm_cnt < FRM_W'(7)) data_sr <= {data_sr[15:0], eth_data_i};
      if (frm_cnt == FRM_W'(7) && sync_ok) begin
        cmd_ptt_o  <= c0[0];
        cmd_addr_o <= c0[6:1];
        cmd_resp_o <= c0[7];
        cmd_data_o <= {data_sr, eth_data_i};
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sample_assembler.sv ====
/* slot to sample word assembler */
`timescale 1ns/1ps
`default_nettype none

module sample_assembler import hl_pkg::*; (
  input  wire logic       clk_ctrl,
  input  wire logic       rst_n_i,
  input  wire logic [7:0] smp_byte_i,
  input  wire logic       smp_byte_vld_i,
  input  wire logic       slot_start_i,
  output lr_sample_t      lr_word_o,
  output iq_sample_t      iq_word_o,
  output logic            wr_o
);

  // left, right, I, Q, high byte first
  logic [63:0] slot_sr;
  logic [2:0]  byte_cnt;

  always_ff @(posedge clk_ctrl) begin
    if (smp_byte_vld_i) begin
      slot_sr <= {slot_sr[55:0], smp_byte_i};
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      byte_cnt <= '0;
      wr_o     <= 1'b0;
    end else begin
      wr_o <= 1'b0;
      if (smp_byte_vld_i) begin
        if (slot_start_i) begin
          byte_cnt <= 3'd1;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
          // eighth byte of the slot
          if (byte_cnt == 3'd7) wr_o <= 1'b1;
        end
      end
    end
  end

  // slot register holds the full slot while wr_o is high
  assign lr_word_o = lr_sample_t'(slot_sr[63:32]);
  assign iq_word_o = iq_sample_t'(slot_sr[31:0]);

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
/* sample fifo, fall-through read */
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk_ctrl,
  input  wire logic     rst_n_i,
  input  wire logic     wr_i,
  input  wire payload_t wr_data_i,
  output payload_t      rd_tdata_o,
  output logic          rd_tvalid_o,
  input  wire logic     rd_tready_i,
  output logic          overflow_o
);

  localparam int AW = $clog2(DEPTH);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          push;
  logic          pop;

  assign full = (count == (AW+1)'(DEPTH));
  assign push = wr_i && !full;
  assign pop  = rd_tvalid_o && rd_tready_i;

  always_ff @(posedge clk_ctrl) begin
    if (push) mem[wr_ptr] <= wr_data_i;
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (AW+1)'(push) - (AW+1)'(pop);
      // sticky until reset
      if (wr_i && full) overflow_o <= 1'b1;
    end
  end

  // head word is visible as soon as the count is nonzero
  assign rd_tvalid_o = (count != '0);
  assign rd_tdata_o  = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== hdl/ctrl_regs.sv ====
/* command register block */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import hl_pkg::*; (
  input  wire logic      clk_ctrl,
  input  wire logic      rst_n_i,
  input  wire logic      cmd_stb_i,
  input  wire cmd_addr_t cmd_addr_i,
  input  wire cmd_data_t cmd_data_i,
  input  wire logic      cmd_ptt_i,
  input  wire logic      cmd_resp_i,
  output logic           tx_on_o,
  output logic           resp_rqst_o,
  output cmd_addr_t      resp_addr_o,
  output cmd_data_t      config_o,
  output cmd_data_t      tx_freq_o,
  output cmd_data_t      rx1_freq_o
);

  ////////////////////////////////////////////////////////////////////////////
  // register bank

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      config_o   <= '0;
      tx_freq_o  <= '0;
      rx1_freq_o <= '0;
    end else if (cmd_stb_i) begin
      case (cmd_addr_i)
        REG_CONFIG:   config_o   <= cmd_data_i;
        REG_TX_FREQ:  tx_freq_o  <= cmd_data_i;
        REG_RX1_FREQ: rx1_freq_o <= cmd_data_i;
        // other addresses belong to blocks outside this design
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // transmit-on and response request

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      tx_on_o     <= 1'b0;
      resp_rqst_o <= 1'b0;
      resp_addr_o <= '0;
    end else begin
      resp_rqst_o <= 1'b0;
      if (cmd_stb_i) begin
        // every command carries ptt
        tx_on_o     <= cmd_ptt_i;
        resp_rqst_o <= cmd_resp_i;
        if (cmd_resp_i) resp_addr_o <= cmd_addr_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hl_ds_top.sv ====
/* downstream front end top level */
`timescale 1ns/1ps
`default_nettype none

module hl_ds_top import hl_pkg::*; #(
  parameter int IQ_DEPTH = 64,
  parameter int LR_DEPTH = 16
) (
  input  wire logic        clk_ctrl,
  input  wire logic        rst_n_i,
  input  wire logic        eth_valid_i,
  input  wire logic [7:0]  eth_data_i,
  input  wire logic [15:0] eth_port_i,
  input  wire logic        eth_broadcast_i,
  output logic             run_o,
  output logic             wide_spectrum_o,
  output logic             discovery_o,
  output logic             tx_on_o,
  output logic             resp_rqst_o,
  output cmd_addr_t        resp_addr_o,
  output cmd_data_t        config_o,
  output cmd_data_t        tx_freq_o,
  output cmd_data_t        rx1_freq_o,
  output iq_sample_t       iq_tdata_o,
  output logic             iq_tvalid_o,
  input  wire logic        iq_tready_i,
  output logic             iq_overflow_o,
  output lr_sample_t       lr_tdata_o,
  output logic             lr_tvalid_o,
  input  wire logic        lr_tready_i,
  output logic             lr_overflow_o
);

  logic       cmd_stb;
  cmd_addr_t  cmd_addr;
  cmd_data_t  cmd_data;
  logic       cmd_ptt;
  logic       cmd_resp;
  logic [7:0] smp_byte;
  logic       smp_byte_vld;
  logic       slot_start;
  lr_sample_t lr_word;
  iq_sample_t iq_word;
  logic       smp_wr;

  ////////////////////////////////////////////////////////////////////////////
  // parser and command registers

  ds_frame_parser parser_i (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .eth_valid_i     (eth_valid_i),
    .eth_data_i      (eth_data_i),
    .eth_port_i      (eth_port_i),
    .eth_broadcast_i (eth_broadcast_i),
    .cmd_stb_o       (cmd_stb),
    .cmd_addr_o      (cmd_addr),
    .cmd_data_o      (cmd_data),
    .cmd_ptt_o       (cmd_ptt),
    .cmd_resp_o      (cmd_resp),
    .smp_byte_o      (smp_byte),
    .smp_byte_vld_o  (smp_byte_vld),
    .slot_start_o    (slot_start),
    .run_o           (run_o),
    .wide_spectrum_o (wide_spectrum_o),
    .discovery_o     (discovery_o)
  );

  ctrl_regs regs_i (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .cmd_stb_i   (cmd_stb),
    .cmd_addr_i  (cmd_addr),
    .cmd_data_i  (cmd_data),
    .cmd_ptt_i   (cmd_ptt),
    .cmd_resp_i  (cmd_resp),
    .tx_on_o     (tx_on_o),
    .resp_rqst_o (resp_rqst_o),
    .resp_addr_o (resp_addr_o),
    .config_o    (config_o),
    .tx_freq_o   (tx_freq_o),
    .rx1_freq_o  (rx1_freq_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // sample path

  sample_assembler asm_i (
    .clk_ctrl       (clk_ctrl),
    .rst_n_i        (rst_n_i),
    .smp_byte_i     (smp_byte),
    .smp_byte_vld_i (smp_byte_vld),
    .slot_start_i   (slot_start),
    .lr_word_o      (lr_word),
    .iq_word_o      (iq_word),
    .wr_o           (smp_wr)
  );

  sample_fifo #(.DEPTH(IQ_DEPTH), .payload_t(iq_sample_t)) iq_fifo_i (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .wr_i        (smp_wr),
    .wr_data_i   (iq_word),
    .rd_tdata_o  (iq_tdata_o),
    .rd_tvalid_o (iq_tvalid_o),
    .rd_tready_i (iq_tready_i),
    .overflow_o  (iq_overflow_o)
  );

  sample_fifo #(.DEPTH(LR_DEPTH), .payload_t(lr_sample_t)) lr_fifo_i (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .wr_i        (smp_wr),
    .wr_data_i   (lr_word),
    .rd_tdata_o  (lr_tdata_o),
    .rd_tvalid_o (lr_tvalid_o),
    .rd_tready_i (lr_tready_i),
    .overflow_o  (lr_overflow_o)
  );

endmodule

`default_nettype wire

// ==== tests/hl_ds_checker.sv ====
/* bound protocol assertions */
`timescale 1ns/1ps
`default_nettype none

module hl_ds_checker (
  input wire logic clk_ctrl,
  input wire logic rst_n_i,
  input wire logic discovery_i,
  input wire logic resp_rqst_i,
  input wire logic iq_overflow_i,
  input wire logic lr_overflow_i,
  input wire logic iq_tvalid_i,
  input wire logic lr_tvalid_i
);

  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // single-cycle pulses

  disc_pulse_a: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    discovery_i |=> !discovery_i)
    else begin
      fail_cnt++;
      $error("discovery_o stayed high for more than one cycle");
    end

  resp_pulse_a: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    resp_rqst_i |=> !resp_rqst_i)
    else begin
      fail_cnt++;
      $error("resp_rqst_o stayed high for more than one cycle");
    end

  ////////////////////////////////////////////////////////////////////////////
  // sticky overflow, clean FIFO outputs out of reset

  iq_ovf_a: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    iq_overflow_i |=> iq_overflow_i)
    else begin
      fail_cnt++;
      $error("iq_overflow_o fell without a reset");
    end

  lr_ovf_a: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    lr_overflow_i |=> lr_overflow_i)
    else begin
      fail_cnt++;
      $error("lr_overflow_o fell without a reset");
    end

  rst_valid_a: assert property (@(posedge clk_ctrl)
    !rst_n_i |=> !iq_tvalid_i && !lr_tvalid_i)
    else begin
      fail_cnt++;
      $error("FIFO tvalid high in the cycle after reset");
    end

endmodule

bind hl_ds_top hl_ds_checker checker_i (
  .clk_ctrl      (clk_ctrl),
  .rst_n_i       (rst_n_i),
  .discovery_i   (discovery_o),
  .resp_rqst_i   (resp_rqst_o),
  .iq_overflow_i (iq_overflow_o),
  .lr_overflow_i (lr_overflow_o),
  .iq_tvalid_i   (iq_tvalid_o),
  .lr_tvalid_i   (lr_tvalid_o)
);

`default_nettype wire

// ==== tests/tb_hl_ds_top.sv ====
/* downstream front end testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_hl_ds_top import hl_pkg::*; ();

  localparam int          CLK_PERIOD = 100;
  localparam int          IQ_DEPTH   = 64;
  localparam int          LR_DEPTH   = 16;
  localparam int          N_RAND_PKT = 6;
  // random data, start/stop x3, discovery x2, bad port, bad header, bad sync, overflow
  localparam int          N_PKT      = N_RAND_PKT + 9;
  localparam logic [31:0] SEED       = 32'h7b8828fb;

  logic        clk_ctrl = 1'b0;
  logic        rst_n_i;
  logic        eth_valid_i;
  logic [7:0]  eth_data_i;
  logic [15:0] eth_port_i;
  logic        eth_broadcast_i;
  logic        run_o;
  logic        wide_spectrum_o;
  logic        discovery_o;
  logic        tx_on_o;
  logic        resp_rqst_o;
  cmd_addr_t   resp_addr_o;
  cmd_data_t   config_o;
  cmd_data_t   tx_freq_o;
  cmd_data_t   rx1_freq_o;
  iq_sample_t  iq_tdata_o;
  logic        iq_tvalid_o;
  logic        iq_tready_i;
  logic        iq_overflow_o;
  lr_sample_t  lr_tdata_o;
  logic        lr_tvalid_o;
  logic        lr_tready_i;
  logic        lr_overflow_o;

  // expected state
  lr_sample_t  exp_lr[$];
  iq_sample_t  exp_iq[$];
  cmd_addr_t   exp_resp[$];
  cmd_data_t   exp_config;
  cmd_data_t   exp_tx_freq;
  cmd_data_t   exp_rx1_freq;
  logic        exp_tx_on;
  logic        exp_run;
  logic        exp_wide;
  int          exp_disc;
  int          disc_cnt  = 0;
  int          chk_cnt   = 0;
  int          err_cnt   = 0;
  // IQ slots the FIFO can still take, negative means no limit
  int          iq_room   = -1;
  logic        iq_hold   = 1'b0;
  logic [31:0] stim_lfsr = SEED;
  logic [31:0] rdy_lfsr  = SEED;

  hl_ds_top #(.IQ_DEPTH(IQ_DEPTH), .LR_DEPTH(LR_DEPTH)) dut_i (.*);

  initial begin
    forever #(CLK_PERIOD / 2) clk_ctrl = ~clk_ctrl;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // galois form, taps 32 22 2 1
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r         = {r[30:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return r;
  endfunction

  // a register loads only on its own address
  function automatic cmd_data_t reg_after(input cmd_addr_t addr, input cmd_data_t data,
                                         input cmd_addr_t reg_addr, input cmd_data_t old);
    return (addr == reg_addr) ? data : old;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_outputs(input string what);
    check_value(config_o, exp_config, {what, ": config_o"});
    check_value(tx_freq_o, exp_tx_freq, {what, ": tx_freq_o"});
    check_value(rx1_freq_o, exp_rx1_freq, {what, ": rx1_freq_o"});
    check_value(tx_on_o, exp_tx_on, {what, ": tx_on_o"});
    check_value(run_o, exp_run, {what, ": run_o"});
    check_value(wide_spectrum_o, exp_wide, {what, ": wide_spectrum_o"});
    check_value(disc_cnt, exp_disc, {what, ": discovery pulses"});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stream drivers

  task automatic send_byte(input logic [7:0] b);
    @(negedge clk_ctrl);
    eth_valid_i = 1'b1;
    eth_data_i  = b;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_ctrl);
      eth_valid_i = 1'b0;
      eth_data_i  = 8'h00;
    end
  endtask

  task automatic send_frame(input logic accept, input logic bad_sync);
    logic [63:0] slot;
    logic [7:0]  c0;
    cmd_addr_t   addr;
    cmd_data_t   data;
    int          bad_pos;
    bad_pos = bad_sync ? int'(rand_bits(2)) % 3 : -1;
    for (int k = 0; k < 3; k++) begin
      send_byte(k == bad_pos ? FRAME_SYNC ^ (8'h01 << rand_bits(3)) : FRAME_SYNC);
    end
    // half the commands aim at the implemented registers
    if (rand_bits(1) != 0) addr = cmd_addr_t'(rand_bits(2));
    else addr = cmd_addr_t'(rand_bits(CMD_ADDR_W));
    c0   = {1'(rand_bits(1)), addr, 1'(rand_bits(1))};
    data = rand_bits(32);
    if (accept && !bad_sync) begin
      exp_config   = reg_after(addr, data, REG_CONFIG, exp_config);
      exp_tx_freq  = reg_after(addr, data, REG_TX_FREQ, exp_tx_freq);
      exp_rx1_freq = reg_after(addr, data, REG_RX1_FREQ, exp_rx1_freq);
      exp_tx_on    = c0[0];
      if (c0[7]) exp_resp.push_back(addr);
    end
    send_byte(c0);
    for (int b = 3; b >= 0; b--) send_byte(data[8*b +: 8]);
    for (int s = 0; s < SLOTS_PER_FRAME; s++) begin
      slot = {rand_bits(32), rand_bits(32)};
      if (accept && !bad_sync) begin
        exp_lr.push_back(lr_sample_t'(slot[63:32]));
        if (iq_room != 0) begin
          exp_iq.push_back(iq_sample_t'(slot[31:0]));
          if (iq_room > 0) iq_room--;
        end
      end
      for (int b = 7; b >= 0; b--) send_byte(slot[8*b +: 8]);
    end
  endtask

  // bad_frame selects a frame with a broken sync byte, -1 for none
  task automatic send_data_packet(input logic [15:0] port, input logic hdr_ok,
                                  input int bad_frame);
    logic accept;
    accept          = (port == DATA_PORT) && hdr_ok;
    eth_port_i      = port;
    eth_broadcast_i = 1'b0;
    send_byte(ETH_SYNC0);
    send_byte(hdr_ok ? ETH_SYNC1 : ~ETH_SYNC1);
    send_byte(PKT_DATA);
    send_byte(8'h02);
    for (int k = 0; k < 4; k++) send_byte(8'(rand_bits(8)));
    send_frame(accept, bad_frame == 0);
    check_outputs("data frame 0");
    send_frame(accept, bad_frame == 1);
    check_outputs("data frame 1");
    idle(4);
  endtask

  task automatic send_short_packet(input logic [7:0] ptype, input logic [7:0] b3,
                                   input logic bcast);
    eth_port_i      = DATA_PORT;
    eth_broadcast_i = bcast;
    send_byte(ETH_SYNC0);
    send_byte(ETH_SYNC1);
    send_byte(ptype);
    send_byte(b3);
    repeat (60) send_byte(8'h00);
    idle(4);
  endtask

  task automatic wait_drain();
    while (exp_lr.size() != 0 || exp_iq.size() != 0) @(negedge clk_ctrl);
    idle(4);
    check_value(lr_tvalid_o, 1'b0, "lr_tvalid_o after drain");
    check_value(iq_tvalid_o, 1'b0, "iq_tvalid_o after drain");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitors

  initial begin
    lr_tready_i = 1'b0;
    iq_tready_i = 1'b0;
    forever begin
      @(negedge clk_ctrl);
      lr_tready_i = rdy_lfsr[0];
      rdy_lfsr    = lfsr_next(rdy_lfsr);
      iq_tready_i = rdy_lfsr[0] && !iq_hold;
      rdy_lfsr    = lfsr_next(rdy_lfsr);
    end
  end

  always @(posedge clk_ctrl) begin
    if (rst_n_i) begin
      if (lr_tvalid_o && lr_tready_i) begin
        if (exp_lr.size() == 0) begin
          err_cnt++;
          $display("LR output delivered a word that no accepted slot produced");
        end else begin
          check_value(lr_tdata_o, exp_lr.pop_front(), "lr_tdata_o");
        end
      end
      if (iq_tvalid_o && iq_tready_i) begin
        if (exp_iq.size() == 0) begin
          err_cnt++;
          $display("IQ output delivered a word that no accepted slot produced");
        end else begin
          check_value(iq_tdata_o, exp_iq.pop_front(), "iq_tdata_o");
        end
      end
      if (resp_rqst_o) begin
        if (exp_resp.size() == 0) begin
          err_cnt++;
          $display("response request raised without a command asking for it");
        end else begin
          check_value(resp_addr_o, exp_resp.pop_front(), "resp_addr_o");
        end
      end
      if (discovery_o) disc_cnt++;
    end
  end

  initial begin
    repeat (N_PKT * 1100) @(posedge clk_ctrl);
    $display("timeout, the test sequence did not finish within %0d cycles", N_PKT * 1100);
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    rst_n_i         = 1'b0;
    eth_valid_i     = 1'b0;
    eth_data_i      = 8'h00;
    eth_port_i      = 16'h0000;
    eth_broadcast_i = 1'b0;
    exp_config      = '0;
    exp_tx_freq     = '0;
    exp_rx1_freq    = '0;
    exp_tx_on       = 1'b0;
    exp_run         = 1'b0;
    exp_wide        = 1'b0;
    exp_disc        = 0;
    repeat (4) @(negedge clk_ctrl);
    rst_n_i = 1'b1;
    idle(2);
    check_outputs("after reset");

    // run state and discovery
    send_short_packet(PKT_START_STOP, 8'h03, 1'b0);
    exp_run  = 1'b1;
    exp_wide = 1'b1;
    check_outputs("start with wide spectrum");
    send_short_packet(PKT_START_STOP, 8'h01, 1'b0);
    exp_wide = 1'b0;
    check_outputs("start without wide spectrum");
    send_short_packet(PKT_START_STOP, 8'h02, 1'b0);
    exp_run  = 1'b0;
    exp_wide = 1'b1;
    check_outputs("stop with wide spectrum");
    send_short_packet(PKT_DISCOVERY, 8'h00, 1'b1);
    exp_disc++;
    check_outputs("broadcast discovery");
    send_short_packet(PKT_DISCOVERY, 8'h00, 1'b0);
    check_outputs("unicast discovery");

    // commands and samples
    repeat (N_RAND_PKT) send_data_packet(DATA_PORT, 1'b1, -1);

    // rejected traffic
    send_data_packet(DATA_PORT + 16'd1, 1'b1, -1);
    send_data_packet(DATA_PORT, 1'b0, -1);
    send_data_packet(DATA_PORT, 1'b1, 1);
    wait_drain();
    check_value(iq_overflow_o, 1'b0, "iq_overflow_o before stall");
    check_value(lr_overflow_o, 1'b0, "lr_overflow_o before stall");

    // stalled IQ reader
    iq_hold = 1'b1;
    iq_room = IQ_DEPTH;
    send_data_packet(DATA_PORT, 1'b1, -1);
    check_value(iq_overflow_o, 1'b1, "iq_overflow_o after stall");
    check_value(lr_overflow_o, 1'b0, "lr_overflow_o after stall");
    iq_hold = 1'b0;
    iq_room = -1;
    wait_drain();
    check_value(exp_resp.size(), 0, "pending response requests");
    check_outputs("end of run");

    $display("checks %0d, value errors %0d, assertion failures %0d",
             chk_cnt, err_cnt, dut_i.checker_i.fail_cnt);
    if (err_cnt == 0 && dut_i.checker_i.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/hl_pkg.sv
hdl/ds_frame_parser.sv
hdl/sample_assembler.sv
hdl/sample_fifo.sv
hdl/ctrl_regs.sv
hdl/hl_ds_top.sv
tests/hl_ds_checker.sv
tests/tb_hl_ds_top.sv

// ==== Bender.yml ====
package:
  name: hl_ds

sources:
  - files:
      - hdl/hl_pkg.sv
      - hdl/ds_frame_parser.sv
      - hdl/sample_assembler.sv
      - hdl/sample_fifo.sv
      - hdl/ctrl_regs.sv
      - hdl/hl_ds_top.sv
  - target: test
    files:
      - tests/hl_ds_checker.sv
      - tests/tb_hl_ds_top.sv
